//--- Bender.yml
package:
  name: sha2_engine

sources:
  - include_dirs:
      - common
    files:
      - common/sha2_pkg.sv
      - sha2/sha2_msg_sched.sv
      - sha2/sha2_round.sv
      - sha2/sha2_core.sv
  - target: test
    include_dirs:
      - common
      - test
    files:
      - test/tb_sha2.sv

//--- common/sha2_defines.svh
`ifndef SHA2_DEFINES_SVH
`define SHA2_DEFINES_SVH

// state and schedule word, 32-bit modes use the low half
`define SHA2_WORD_W 64

// beats per block
`define SHA2_BLOCK_WORDS 16

// rounds per block, 224/256
`define SHA2_ROUNDS_32 64

// rounds per block, 384/512
`define SHA2_ROUNDS_64 80

// right-aligned digest output
`define SHA2_DIGEST_W 512

`endif

//--- common/sha2_pkg.sv
`include "sha2_defines.svh"

package sha2_pkg;

    typedef logic [`SHA2_WORD_W-1:0]               sha2_word_t;
    typedef logic [`SHA2_DIGEST_W-1:0]             sha2_digest_t;
    typedef logic [$clog2(`SHA2_ROUNDS_64)-1:0]    sha2_round_t;

    // bit 1 selects 64-bit words
    typedef enum logic [1:0] {
        SHA_224 = 2'd0,
        SHA_256 = 2'd1,
        SHA_384 = 2'd2,
        SHA_512 = 2'd3
    } sha2_mode_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        EXPAND,
        FINAL,
        DONE
    } core_state_e;

    typedef struct packed {
        sha2_word_t a;
        sha2_word_t b;
        sha2_word_t c;
        sha2_word_t d;
        sha2_word_t e;
        sha2_word_t f;
        sha2_word_t g;
        sha2_word_t h;
    } sha2_hash_t;

    // sha-256 constants are the upper halves of these
    localparam sha2_word_t SHA2_K64 [`SHA2_ROUNDS_64] = '{
        64'h428a2f98d728ae22, 64'h7137449123ef65cd, 64'hb5c0fbcfec4d3b2f, 64'he9b5dba58189dbbc,
        64'h3956c25bf348b538, 64'h59f111f1b605d019, 64'h923f82a4af194f9b, 64'hab1c5ed5da6d8118,
        64'hd807aa98a3030242, 64'h12835b0145706fbe, 64'h243185be4ee4b28c, 64'h550c7dc3d5ffb4e2,
        64'h72be5d74f27b896f, 64'h80deb1fe3b1696b1, 64'h9bdc06a725c71235, 64'hc19bf174cf692694,
        64'he49b69c19ef14ad2, 64'hefbe4786384f25e3, 64'h0fc19dc68b8cd5b5, 64'h240ca1cc77ac9c65,
        64'h2de92c6f592b0275, 64'h4a7484aa6ea6e483, 64'h5cb0a9dcbd41fbd4, 64'h76f988da831153b5,
        64'h983e5152ee66dfab, 64'ha831c66d2db43210, 64'hb00327c898fb213f, 64'hbf597fc7beef0ee4,
        64'hc6e00bf33da88fc2, 64'hd5a79147930aa725, 64'h06ca6351e003826f, 64'h142929670a0e6e70,
        64'h27b70a8546d22ffc, 64'h2e1b21385c26c926, 64'h4d2c6dfc5ac42aed, 64'h53380d139d95b3df,
        64'h650a73548baf63de, 64'h766a0abb3c77b2a8, 64'h81c2c92e47edaee6, 64'h92722c851482353b,
        64'ha2bfe8a14cf10364, 64'ha81a664bbc423001, 64'hc24b8b70d0f89791, 64'hc76c51a30654be30,
        64'hd192e819d6ef5218, 64'hd69906245565a910, 64'hf40e35855771202a, 64'h106aa07032bbd1b8,
        64'h19a4c116b8d2d0c8, 64'h1e376c085141ab53, 64'h2748774cdf8eeb99, 64'h34b0bcb5e19b48a8,
        64'h391c0cb3c5c95a63, 64'h4ed8aa4ae3418acb, 64'h5b9cca4f7763e373, 64'h682e6ff3d6b2b8a3,
        64'h748f82ee5defb2fc, 64'h78a5636f43172f60, 64'h84c87814a1f0ab72, 64'h8cc702081a6439ec,
        64'h90befffa23631e28, 64'ha4506cebde82bde9, 64'hbef9a3f7b2c67915, 64'hc67178f2e372532b,
        64'hca273eceea26619c, 64'hd186b8c721c0c207, 64'heada7dd6cde0eb1e, 64'hf57d4f7fee6ed178,
        64'h06f067aa72176fba, 64'h0a637dc5a2c898a6, 64'h113f9804bef90dae, 64'h1b710b35131c471b,
        64'h28db77f523047d84, 64'h32caab7b40c72493, 64'h3c9ebe0a15c9bebc, 64'h431d67c49c100d4c,
        64'h4cc5d4becb3e42b6, 64'h597f299cfc657e2a, 64'h5fcb6fab3ad6faec, 64'h6c44198c4a475817
    };

    // sha-224 iv is the low half of this one
    localparam sha2_word_t SHA2_IV384 [8] = '{
        64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507, 64'h9159015a3070dd17, 64'h152fecd8f70e5939,
        64'h67332667ffc00b31, 64'h8eb44a8768581511, 64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4
    };

    // sha-256 iv is the high half of this one
    localparam sha2_word_t SHA2_IV512 [8] = '{
        64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
        64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
    };

    function automatic sha2_word_t sha2_trim(sha2_word_t x, sha2_mode_e mode);
        return mode[1] ? x : {32'h0, x[31:0]};
    endfunction

    // rotate right within the word width of the mode
    function automatic sha2_word_t sha2_rotr(sha2_word_t x, int unsigned n, sha2_mode_e mode);
        logic [31:0] lo;
        logic [31:0] lo_rot;
        lo     = x[31:0];
        lo_rot = (lo >> n) | (lo << (32 - n));
        if (mode[1]) begin
            return (x >> n) | (x << (64 - n));
        end
        return {32'h0, lo_rot};
    endfunction

    function automatic sha2_word_t sha2_k(sha2_round_t rnd, sha2_mode_e mode);
        sha2_word_t k;
        k = SHA2_K64[rnd];
        return mode[1] ? k : {32'h0, k[63:32]};
    endfunction

    function automatic sha2_hash_t sha2_iv(sha2_mode_e mode);
        sha2_word_t iv [8];
        for (int i = 0; i < 8; i++) begin
            case (mode)
                SHA_224: iv[i] = {32'h0, SHA2_IV384[i][31:0]};
                SHA_256: iv[i] = {32'h0, SHA2_IV512[i][63:32]};
                SHA_384: iv[i] = SHA2_IV384[i];
                default: iv[i] = SHA2_IV512[i];
            endcase
        end
        return {iv[0], iv[1], iv[2], iv[3], iv[4], iv[5], iv[6], iv[7]};
    endfunction

endpackage

//--- files.f
+incdir+common
+incdir+test
common/sha2_pkg.sv
sha2/sha2_msg_sched.sv
sha2/sha2_round.sv
sha2/sha2_core.sv
test/tb_sha2.sv

//--- sha2/sha2_core.sv
`timescale 1ns/10ps
`include "sha2_defines.svh"

module sha2_core (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  sha2_pkg::sha2_mode_e   in_mode_i,
    input  logic                   in_last_i,
    input  sha2_pkg::sha2_word_t   in_data_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    output sha2_pkg::sha2_digest_t out_data_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i
);
    import sha2_pkg::*;

    core_state_e  state_q;
    sha2_mode_e   mode_q;
    sha2_mode_e   mode_cur;
    logic         last_q;
    logic [3:0]   bcnt_q;      // beats taken in this block
    sha2_round_t  rnd_q;       // index of the word at the window head
    sha2_round_t  last_rnd;
    logic         step_q;
    logic         in_fire;
    logic         out_fire;
    logic         sched_load;
    logic         sched_expand;
    logic         rnd_init;
    logic         rnd_begin;
    logic         rnd_finish;
    logic [31:0]  lo_swap;
    sha2_word_t   word_swap;
    sha2_word_t   w_cur;
    sha2_hash_t   hash;
    sha2_digest_t digest;

    assign in_ready_o = (state_q == IDLE) || (state_q == LOAD);
    assign in_fire    = in_valid_i && in_ready_o;
    assign out_fire   = out_valid_o && out_ready_i;

    // mode is taken from the port on the first beat
    assign mode_cur = (state_q == IDLE) ? in_mode_i : mode_q;
    assign last_rnd = mode_q[1] ? sha2_round_t'(`SHA2_ROUNDS_64 - 1)
                                : sha2_round_t'(`SHA2_ROUNDS_32 - 1);

    assign sched_load   = in_fire;
    assign sched_expand = (state_q == EXPAND) && (rnd_q != last_rnd);
    assign rnd_init     = in_fire && (state_q == IDLE);
    assign rnd_begin    = (state_q == LOAD) && (bcnt_q == 4'd0);    // later blocks only
    assign rnd_finish   = (state_q == FINAL);

    // little-endian beat to big-endian word
    always_comb begin
        lo_swap = {<<8{in_data_i[31:0]}};
        if (mode_cur[1]) begin
            word_swap = {<<8{in_data_i}};
        end else begin
            word_swap = {32'h0, lo_swap};
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            mode_q  <= SHA_224;
            last_q  <= 1'b0;
            bcnt_q  <= 4'd0;
            rnd_q   <= '0;
            step_q  <= 1'b0;
        end else begin
            step_q <= sched_load || sched_expand;    // round runs one cycle behind W
            if (sched_load) begin
                rnd_q  <= sha2_round_t'(bcnt_q);
                bcnt_q <= bcnt_q + 1'b1;
            end else if (sched_expand) begin
                rnd_q <= rnd_q + 1'b1;
            end

            case (state_q)
                IDLE: begin
                    if (in_fire) begin
                        mode_q  <= in_mode_i;
                        state_q <= LOAD;
                    end
                end
                LOAD: begin
                    if (in_fire && bcnt_q == 4'(`SHA2_BLOCK_WORDS - 1)) begin
                        last_q  <= in_last_i;
                        state_q <= EXPAND;
                    end
                end
                EXPAND: begin
                    if (rnd_q == last_rnd) begin
                        state_q <= FINAL;
                    end
                end
                FINAL: begin
                    state_q <= last_q ? DONE : LOAD;
                end
                DONE: begin
                    if (out_fire) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    sha2_msg_sched u_sched (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .mode_i   (mode_cur),
        .load_i   (sched_load),
        .word_i   (word_swap),
        .expand_i (sched_expand),
        .w_o      (w_cur)
    );

    sha2_round u_round (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .mode_i   (mode_cur),
        .init_i   (rnd_init),
        .begin_i  (rnd_begin),
        .step_i   (step_q),
        .finish_i (rnd_finish),
        .round_i  (rnd_q),
        .w_i      (w_cur),
        .hash_o   (hash)
    );

    // first word lands in the top of the used width
    always_comb begin
        digest = '0;
        case (mode_q)
            SHA_224: digest[223:0] = {hash.a[31:0], hash.b[31:0], hash.c[31:0], hash.d[31:0],
                                      hash.e[31:0], hash.f[31:0], hash.g[31:0]};
            SHA_256: digest[255:0] = {hash.a[31:0], hash.b[31:0], hash.c[31:0], hash.d[31:0],
                                      hash.e[31:0], hash.f[31:0], hash.g[31:0], hash.h[31:0]};
            SHA_384: digest[383:0] = {hash.a, hash.b, hash.c, hash.d, hash.e, hash.f};
            SHA_512: digest        = hash;
            default: digest        = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (state_q == DONE && !out_valid_o) begin
            out_valid_o <= 1'b1;
        end else if (out_fire) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == DONE && !out_valid_o) begin
            out_data_o <= digest;
        end
    end

    a_out_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
    ) else $error("digest changed under back-pressure");

    a_round_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) rnd_q <= last_rnd
    ) else $error("round counter past the last round of the mode");

endmodule

//--- sha2/sha2_msg_sched.sv
`timescale 1ns/10ps
`include "sha2_defines.svh"

module sha2_msg_sched (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  sha2_pkg::sha2_mode_e mode_i,
    input  logic                 load_i,
    input  sha2_pkg::sha2_word_t word_i,
    input  logic                 expand_i,
    output sha2_pkg::sha2_word_t w_o
);
    import sha2_pkg::*;

    sha2_word_t win_q [`SHA2_BLOCK_WORDS];    // [0] is the newest word
    sha2_word_t x;
    sha2_word_t y;
    sha2_word_t sig0;
    sha2_word_t sig1;
    sha2_word_t w_new;

    always_comb begin
        x = win_q[14];    // W[t-15]
        y = win_q[1];     // W[t-2]
        if (mode_i[1]) begin
            sig0 = sha2_rotr(x, 1, mode_i) ^ sha2_rotr(x, 8, mode_i) ^ (x >> 7);
            sig1 = sha2_rotr(y, 19, mode_i) ^ sha2_rotr(y, 61, mode_i) ^ (y >> 6);
        end else begin
            sig0 = sha2_rotr(x, 7, mode_i) ^ sha2_rotr(x, 18, mode_i) ^ (x >> 3);
            sig1 = sha2_rotr(y, 17, mode_i) ^ sha2_rotr(y, 19, mode_i) ^ (y >> 10);
        end
        w_new = sha2_trim(sig1 + win_q[6] + sig0 + win_q[15], mode_i);
    end

    always_ff @(posedge clk_i) begin
        if (load_i || expand_i) begin
            win_q[0] <= load_i ? word_i : w_new;
            for (int i = 1; i < `SHA2_BLOCK_WORDS; i++) begin
                win_q[i] <= win_q[i-1];
            end
        end
    end

    assign w_o = win_q[0];

    // beats and expansion come from different FSM phases of the core
    a_load_expand_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(load_i && expand_i)
    ) else $error("schedule load and expand in the same cycle");

endmodule

//--- sha2/sha2_round.sv
`timescale 1ns/10ps

module sha2_round (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  sha2_pkg::sha2_mode_e  mode_i,
    input  logic                  init_i,
    input  logic                  begin_i,
    input  logic                  step_i,
    input  logic                  finish_i,
    input  sha2_pkg::sha2_round_t round_i,
    input  sha2_pkg::sha2_word_t  w_i,
    output sha2_pkg::sha2_hash_t  hash_o
);
    import sha2_pkg::*;

    sha2_hash_t wv_q;      // working variables a..h
    sha2_hash_t hash_q;    // chaining value
    sha2_hash_t iv;
    sha2_hash_t sum;
    sha2_word_t k_w;
    sha2_word_t bsig0;
    sha2_word_t bsig1;
    sha2_word_t ch;
    sha2_word_t maj;
    sha2_word_t t1;
    sha2_word_t t2;

    assign iv  = sha2_iv(mode_i);
    assign k_w = sha2_k(round_i, mode_i);

    always_comb begin
        if (mode_i[1]) begin
            bsig0 = sha2_rotr(wv_q.a, 28, mode_i) ^ sha2_rotr(wv_q.a, 34, mode_i)
                  ^ sha2_rotr(wv_q.a, 39, mode_i);
            bsig1 = sha2_rotr(wv_q.e, 14, mode_i) ^ sha2_rotr(wv_q.e, 18, mode_i)
                  ^ sha2_rotr(wv_q.e, 41, mode_i);
        end else begin
            bsig0 = sha2_rotr(wv_q.a, 2, mode_i) ^ sha2_rotr(wv_q.a, 13, mode_i)
                  ^ sha2_rotr(wv_q.a, 22, mode_i);
            bsig1 = sha2_rotr(wv_q.e, 6, mode_i) ^ sha2_rotr(wv_q.e, 11, mode_i)
                  ^ sha2_rotr(wv_q.e, 25, mode_i);
        end
        ch  = (wv_q.e & wv_q.f) ^ (~wv_q.e & wv_q.g);    // upper half cleared by trim
        maj = (wv_q.a & wv_q.b) ^ (wv_q.a & wv_q.c) ^ (wv_q.b & wv_q.c);
        t1  = wv_q.h + bsig1 + ch + k_w + w_i;
        t2  = bsig0 + maj;
    end

    // feed-forward into the chaining value
    always_comb begin
        sum.a = sha2_trim(hash_q.a + wv_q.a, mode_i);
        sum.b = sha2_trim(hash_q.b + wv_q.b, mode_i);
        sum.c = sha2_trim(hash_q.c + wv_q.c, mode_i);
        sum.d = sha2_trim(hash_q.d + wv_q.d, mode_i);
        sum.e = sha2_trim(hash_q.e + wv_q.e, mode_i);
        sum.f = sha2_trim(hash_q.f + wv_q.f, mode_i);
        sum.g = sha2_trim(hash_q.g + wv_q.g, mode_i);
        sum.h = sha2_trim(hash_q.h + wv_q.h, mode_i);
    end

    always_ff @(posedge clk_i) begin
        if (init_i) begin
            hash_q <= iv;
            wv_q   <= iv;    // first block starts from the iv directly
        end else if (begin_i) begin
            wv_q <= hash_q;
        end else if (step_i) begin
            wv_q.a <= sha2_trim(t1 + t2, mode_i);
            wv_q.b <= wv_q.a;
            wv_q.c <= wv_q.b;
            wv_q.d <= wv_q.c;
            wv_q.e <= sha2_trim(wv_q.d + t1, mode_i);
            wv_q.f <= wv_q.e;
            wv_q.g <= wv_q.f;
            wv_q.h <= wv_q.g;
        end else if (finish_i) begin
            hash_q <= sum;
        end
    end

    assign hash_o = hash_q;

    a_ctrl_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) $onehot0({init_i, begin_i, step_i, finish_i})
    ) else $error("more than one round control pulse");

endmodule

//--- test/tb_sha2_tasks.svh
localparam sha2_digest_t DIG_224_ABC = {288'h0,
    224'h23097d223405d8228642a477bda255b32aadbce4bda0b3f7e36c9da7};
localparam sha2_digest_t DIG_256_ABC = {256'h0,
    256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad};
localparam sha2_digest_t DIG_256_LONG = {256'h0,
    256'h248d6a61d20638b8e5c026930c3e6039a33ce45964ff2167f6ecedd419db06c1};
localparam sha2_digest_t DIG_384_ABC = {128'h0,
    128'hcb00753f45a35e8bb5a03d699ac65007,
    256'h272c32ab0eded1631a8b605a43ff5bed8086072ba1e7cc2358baeca134c825a7};
localparam sha2_digest_t DIG_512_ABC = {
    256'hddaf35a193617abacc417349ae20413112e6fa4e89a97ea20a9eeee64b55d39a,
    256'h2192992a274fc1a836ba3c23a3feebbd454d4423643ce80e2a9ac94fa54ca49f};

// big-endian message word to the little-endian beat the host sends
function automatic sha2_word_t le_beat(sha2_word_t word, sha2_mode_e mode);
    sha2_word_t beat;
    int         nbytes;
    beat   = '0;
    nbytes = mode[1] ? 8 : 4;
    for (int i = 0; i < nbytes; i++) begin
        beat[8*i +: 8] = word[8*(nbytes-1-i) +: 8];
    end
    return beat;
endfunction

// padded "abc" with word 0 in the top 64 bits
function automatic logic [1023:0] abc_block(sha2_mode_e mode);
    logic [1023:0] blk;
    blk = '0;
    blk[1023 -: 64] = mode[1] ? 64'h6162638000000000 : 64'h0000000061626380;
    blk[63:0]       = 64'h18;    // 24-bit length
    return blk;
endfunction

// "abcdbcdecdef..." padded over two sha-256 blocks
function automatic logic [1023:0] long_block(int idx);
    logic [1023:0] blk;
    logic [7:0]    c;
    blk = '0;
    if (idx == 0) begin
        for (int k = 0; k < 14; k++) begin
            c = 8'h61 + 8'(k);
            blk[1023-64*k -: 64] = {32'h0, c, c + 8'd1, c + 8'd2, c + 8'd3};
        end
        blk[1023-64*14 -: 64] = 64'h80000000;
    end else begin
        blk[63:0] = 64'h1c0;
    end
    return blk;
endfunction

task automatic send_block(input logic [1023:0] blk, input sha2_mode_e mode, input logic last,
                          input int gap, output bit ok);
    int waited;
    bit taken;
    ok = 1'b1;
    for (int i = 0; i < 16; i++) begin
        if (gap > 0 && i > 0) begin
            in_valid <= 1'b0;
            repeat (gap) @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data  <= le_beat(blk[1023-64*i -: 64], mode);
        in_mode  <= mode;
        in_last  <= last && (i == 15);
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < BEAT_TIMEOUT) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            waited++;
        end
        if (!taken) begin
            $display("beat %0d was never accepted, in_ready stayed low", i);
            fail_cnt++;
            ok = 1'b0;
            in_valid <= 1'b0;
            return;
        end
    end
    in_valid <= 1'b0;
    in_last  <= 1'b0;
endtask

// leaves the caller at the falling edge where out_valid was first seen
task automatic expect_digest(input string name, input sha2_digest_t exp, input int exp_lat);
    int lat;
    bit seen;
    seen = 1'b0;
    lat  = 0;
    while (!seen && lat < DIGEST_TIMEOUT) begin
        @(posedge clk);
        lat++;    // rising edges since the last beat
        @(negedge clk);
        seen = out_valid;
    end
    if (!seen) begin
        $display("%s: no digest came out within %0d cycles", name, DIGEST_TIMEOUT);
        fail_cnt++;
        return;
    end
    if (out_data !== exp) begin
        $display("FAILED %s digest: expected %h, actual %h", name, exp, out_data);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
    if (lat != exp_lat) begin
        $display("FAILED %s latency: expected %0d, actual %0d", name, exp_lat, lat);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic report_test(input string name, input int errs_before);
    $display("test %s done, %0d errors", name, fail_cnt - errs_before);
endtask

task automatic hash_sha256_abc();
    int errs;
    bit ok;
    errs = fail_cnt;
    send_block(abc_block(SHA_256), SHA_256, 1'b1, 0, ok);
    if (ok) expect_digest("sha256_abc", DIG_256_ABC, 51);
    @(posedge clk);
    report_test("sha256_abc", errs);
endtask

task automatic hash_sha512_abc();
    int errs;
    bit ok;
    errs = fail_cnt;
    send_block(abc_block(SHA_512), SHA_512, 1'b1, 0, ok);
    if (ok) expect_digest("sha512_abc", DIG_512_ABC, 67);
    @(posedge clk);
    report_test("sha512_abc", errs);
endtask

task automatic hash_truncated_modes();
    int errs;
    bit ok;
    errs = fail_cnt;
    send_block(abc_block(SHA_224), SHA_224, 1'b1, 0, ok);
    if (ok) expect_digest("sha224_abc", DIG_224_ABC, 51);
    @(posedge clk);
    send_block(abc_block(SHA_384), SHA_384, 1'b1, 0, ok);
    if (ok) expect_digest("sha384_abc", DIG_384_ABC, 67);
    @(posedge clk);
    report_test("truncated_modes", errs);
endtask

task automatic hash_two_blocks();
    int errs;
    bit ok;
    errs = fail_cnt;
    send_block(long_block(0), SHA_256, 1'b0, 2, ok);
    if (ok) send_block(long_block(1), SHA_256, 1'b1, 3, ok);
    if (ok) expect_digest("sha256_two_blocks", DIG_256_LONG, 51);
    @(posedge clk);
    report_test("sha256_two_blocks", errs);
endtask

task automatic hold_under_backpressure();
    sha2_digest_t held;
    int           errs;
    bit           ok;
    errs = fail_cnt;
    out_ready <= 1'b0;
    send_block(abc_block(SHA_256), SHA_256, 1'b1, 0, ok);
    if (ok) begin
        expect_digest("backpressure", DIG_256_ABC, 51);
        held = out_data;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            @(negedge clk);
            if (out_data !== held) begin
                $display("FAILED backpressure hold: expected %h, actual %h", held, out_data);
                fail_cnt++;
            end else if (out_valid !== 1'b1 || in_ready !== 1'b0) begin
                $display("FAILED backpressure stall %0d: expected valid/ready 10, actual %b%b",
                         i, out_valid, in_ready);
                fail_cnt++;
            end else begin
                pass_cnt++;
            end
        end
    end
    @(posedge clk);
    out_ready <= 1'b1;
    @(posedge clk);    // digest moves on this edge
    @(negedge clk);
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
        $display("FAILED backpressure release: expected valid/ready 01, actual %b%b",
                 out_valid, in_ready);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
    @(posedge clk);
    send_block(abc_block(SHA_512), SHA_512, 1'b1, 0, ok);
    if (ok) expect_digest("backpressure_sha512", DIG_512_ABC, 67);
    @(posedge clk);
    report_test("backpressure", errs);
endtask

task automatic reset_mid_message();
    int errs;
    bit ok;
    errs = fail_cnt;
    send_block(abc_block(SHA_256), SHA_256, 1'b0, 0, ok);    // more blocks would follow
    repeat (10) @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
        $display("FAILED reset_mid_message: expected ready/valid 10, actual %b%b",
                 in_ready, out_valid);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    send_block(abc_block(SHA_256), SHA_256, 1'b1, 0, ok);
    if (ok) expect_digest("reset_then_sha256", DIG_256_ABC, 51);
    @(posedge clk);
    report_test("reset_mid_message", errs);
endtask

//--- test/tb_sha2.sv
`timescale 1ns/10ps

module tb_sha2;
    import sha2_pkg::*;

    localparam int BEAT_TIMEOUT   = 100;
    localparam int DIGEST_TIMEOUT = 150;

    logic         clk;
    logic         rst_n;
    sha2_mode_e   in_mode;
    logic         in_last;
    sha2_word_t   in_data;
    logic         in_valid;
    logic         in_ready;
    sha2_digest_t out_data;
    logic         out_valid;
    logic         out_ready;
    int           pass_cnt;
    int           fail_cnt;

    sha2_core dut0 (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .in_mode_i   (in_mode),
        .in_last_i   (in_last),
        .in_data_i   (in_data),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .out_data_o  (out_data),
        .out_valid_o (out_valid),
        .out_ready_i (out_ready)
    );

    always #4 clk = ~clk;    // 8 ns period

    `include "tb_sha2_tasks.svh"

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_mode   = SHA_256;
        in_last   = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        pass_cnt  = 0;
        fail_cnt  = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        hash_sha256_abc();
        hash_sha512_abc();
        hash_truncated_modes();
        hash_two_blocks();
        hold_under_backpressure();
        reset_mid_message();

        $display("checks passed: %0d, failing: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
